// ==== src.f ====
+incdir+dv
verilog/predecode_pkg.sv
verilog/predecode_skid.sv
verilog/block_xfer_sequencer.sv
verilog/return_address_stack.sv
verilog/branch_predecode.sv
verilog/predecode_top.sv
dv/predecode_tb.sv

// ==== dv/predecode_tb_model.svh ====
/*
 * Pre-decode reference model.
 * Expected decode and redirect entries per instruction, worked out
 * from the branch rules, with its own 8-entry return address stack.
 */
`ifndef PREDECODE_TB_MODEL_SVH
`define PREDECODE_TB_MODEL_SVH

logic [31:0]              m_stack [8];
logic [2:0]               m_ptr;
logic [31:0]              m_ppc;
predecode_pkg::decode_t   exp_dec_q [$];
predecode_pkg::redirect_t exp_red_q [$];
string                    exp_name_q [$];

// Micro-ops that one instruction splits into.
function automatic int count_uops(input logic [31:0] instr);
        if (instr[27:25] == 3'b100 && instr[15:0] != 16'd0)
                return $countones(instr[15:0]);
        return 1;
endfunction

// Queues the expected entries of one instruction, at most max_uops of them.
function automatic int expect_instr(input predecode_pkg::fetch_t f, input int max_uops,
                                    input string name);
        predecode_pkg::decode_t   d;
        predecode_pkg::redirect_t r;
        logic [15:0]              left;
        logic [31:0]              tgt;
        logic                     is_b;
        logic                     ld_pc;
        logic                     ret;
        logic                     jt;
        logic                     guess;
        int                       off;
        int                       n;
        int                       k;
        n     = count_uops(f.instr);
        left  = f.instr[15:0];
        is_b  = f.instr[27:25] == 3'b101;
        ld_pc = (f.instr[27:25] == 3'b010 || (f.instr[27:25] == 3'b011 && !f.instr[4])) &&
                f.instr[20] && f.instr[15:12] == 4'd15;
        ret   = (f.instr[27:0] == 28'h12FFF1E) || (f.instr[27:0] == 28'h1A0F00E) ||
                (f.instr[27:25] == 3'b100 && f.instr[20] && f.instr[15]) ||
                (ld_pc && f.instr[19:16] == 4'd13);
        jt    = ld_pc || (f.instr[27:26] == 2'b00 && f.instr[15:12] == 4'd15 &&
                !(!f.instr[25] && f.instr[7] && f.instr[4]) &&
                (f.instr[24:21] == 4'b0100 || f.instr[24:21] == 4'b1101));
        guess = f.taken == predecode_pkg::wt || f.taken == predecode_pkg::st ||
                f.instr[31:28] == 4'b1110;
        for (k = 0; k < n && k < max_uops; k++)
        begin
                d = {1'b1, f.instr, f.pc, f.taken, m_ppc};
                r = '0;
                if (n > 1)
                begin
                        d.instr[15:0] = left & -left;
                        left          = left & ~d.instr[15:0];
                end
                if (k == n - 1)
                begin
                        if ((is_b || ret) && guess)
                        begin
                                // Word offset, signed.
                                off   = int'($signed(f.instr[23:0])) * 4;
                                tgt   = is_b ? f.pc + 32'd8 + off : m_stack[m_ptr - 3'd1];
                                m_ppc = tgt;
                                r     = {!f.pred_valid || f.pred_addr != tgt, tgt, 1'b0};
                                if (f.instr[31:28] == 4'b1110)
                                        d.taken = predecode_pkg::st;
                                if (is_b && f.instr[24])
                                begin
                                        m_stack[m_ptr] = f.pc + 32'd4;
                                        m_ptr          = m_ptr + 3'd1;
                                end
                                if (ret)
                                        m_ptr = m_ptr - 3'd1;
                        end
                        else if (is_b || ret)
                                m_ppc = f.pc + 32'd4;
                        else if (!jt)
                        begin
                                d.taken = predecode_pkg::snt;
                                if (f.pred_valid)
                                begin
                                        m_ppc = f.pc + 32'd4;
                                        r     = {1'b1, f.pc + 32'd4, 1'b1};
                                end
                        end
                        d.ppc = m_ppc;
                end
                exp_dec_q.push_back(d);
                exp_red_q.push_back(r);
                exp_name_q.push_back(name);
        end
        return k;
endfunction

task automatic check_decode(input string name, input predecode_pkg::decode_t exp,
                            input predecode_pkg::decode_t act);
        if (act !== exp)
        begin
                dec_errors++;
                $display("ERROR %s decode: expected %h actual %h", name, exp, act);
        end
endtask

// The target field only matters when a redirect is raised.
task automatic check_redirect(input string name, input predecode_pkg::redirect_t exp,
                              input predecode_pkg::redirect_t act);
        if (act.clear !== exp.clear || act.clear_btb !== exp.clear_btb ||
            (exp.clear && act.pc !== exp.pc))
        begin
                red_errors++;
                $display("ERROR %s redirect: expected %h actual %h", name, exp, act);
        end
endtask

`endif

// ==== dv/predecode_tb.sv ====
/*
 * Pre-decode stage testbench.
 * Directed and random instructions with random back-pressure, checked
 * entry by entry against the reference model.
 */
`timescale 1ns/1ps

module predecode_tb;

logic                     i_clk;
logic                     i_reset;
logic                     i_stall;
logic                     i_clear;
predecode_pkg::fetch_t    i_fetch;
predecode_pkg::decode_t   o_decode;
predecode_pkg::redirect_t o_redirect;
logic                     o_stall_from_decode;
int                       dec_errors;
int                       red_errors;
int                       misc_errors;
int                       cycles;
int                       cycle_limit;
logic                     edge_upd;
logic                     prev_red;
logic [31:0]              pc_ctr;
predecode_pkg::fetch_t    fetch_q [$];
string                    name_q [$];
bit                       clear_q [$];

`include "predecode_tb_model.svh"

predecode_top #(.RAS_DEPTH(8)) uut
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_fetch             (i_fetch),
        .i_stall             (i_stall),
        .i_clear             (i_clear),
        .o_decode            (o_decode),
        .o_redirect          (o_redirect),
        .o_stall_from_decode (o_stall_from_decode)
);

initial
begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
end

// Remember whether the last edge was an update edge.
always @(posedge i_clk)
begin
        edge_upd <= !i_reset && !i_stall;
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
                $display("Timeout: run passed %0d cycles", cycle_limit);
                $display("FAIL: see errors above");
                $finish;
        end
end

////////////////////
// Compare.
////////////////////

always @(negedge i_clk)
begin
        if (edge_upd === 1'b1)
        begin
                if (prev_red && o_decode.valid)
                begin
                        misc_errors++;
                        $display("Decode output was valid in the cycle after a redirect");
                end
                if (o_decode.valid || o_redirect.clear)
                begin
                        if (exp_dec_q.size() == 0)
                        begin
                                misc_errors++;
                                $display("DUT gave an output that no instruction expects");
                        end
                        else
                        begin
                                check_decode(exp_name_q[0], exp_dec_q.pop_front(), o_decode);
                                check_redirect(exp_name_q.pop_front(), exp_red_q.pop_front(),
                                               o_redirect);
                        end
                end
                prev_red = o_redirect.clear;
        end
end

////////////////////
// Stimulus.
////////////////////

task automatic randomize_stall();
        i_stall = ($urandom % 10) == 0;
endtask

task automatic add_instr(input string name, input logic [31:0] instr,
                         input predecode_pkg::taken_t taken, input logic pv,
                         input logic [31:0] pa, input bit with_clear = 0);
        fetch_q.push_back({pv, pa, taken, pc_ctr, instr, 1'b1});
        name_q.push_back(name);
        clear_q.push_back(with_clear);
        pc_ctr = pc_ctr + 32'd4;
endtask

// Idle bundles until k update edges have gone by.
task automatic drain_idle(input int k);
        int done;
        done    = 0;
        i_fetch = '0;
        while (done < k)
        begin
                randomize_stall();
                if (!i_stall)
                        done++;
                @(negedge i_clk);
        end
endtask

task automatic send_instr(input predecode_pkg::fetch_t f, input string name);
        int   n;
        int   held;
        logic exp_clear;
        n         = expect_instr(f, 16, name);
        exp_clear = exp_red_q[$].clear;
        i_fetch   = f;
        randomize_stall();
        while (i_stall || o_stall_from_decode)
        begin
                @(negedge i_clk);
                randomize_stall();
        end
        @(negedge i_clk);
        if (o_stall_from_decode !== (n > 1))
        begin
                misc_errors++;
                $display("Fetch stall level wrong after %s was taken", name);
        end
        held = 0;
        while (o_stall_from_decode)
        begin
                randomize_stall();
                if (!i_stall)
                        held++;
                @(negedge i_clk);
        end
        if (held != n - 1)
        begin
                misc_errors++;
                $display("Fetch stall for %s lasted %0d update edges instead of %0d",
                         name, held, n - 1);
        end
        // The DUT drops whatever is presented in the redirect cycle.
        if (exp_clear)
        begin
                i_fetch = {1'b0, 32'd0, predecode_pkg::snt, f.pc + 32'd4, 32'hE082_1003, 1'b1};
                randomize_stall();
                while (i_stall)
                begin
                        @(negedge i_clk);
                        randomize_stall();
                end
                @(negedge i_clk);
        end
        drain_idle(2);
endtask

// Two micro-ops go out, then the outside clear drops the rest.
task automatic send_with_clear(input predecode_pkg::fetch_t f, input string name);
        void'(expect_instr(f, 2, name));
        i_fetch = f;
        i_stall = 1'b0;
        repeat (2) @(negedge i_clk);
        i_clear = 1'b1;
        @(negedge i_clk);
        i_clear = 1'b0;
        if (o_stall_from_decode || o_decode.valid)
        begin
                misc_errors++;
                $display("Outside clear did not stop the split of %s", name);
        end
        drain_idle(2);
endtask

initial
begin
        logic [31:0] ins [8];
        int          i;
        int          total;
        void'($urandom(32'h50ac));
        dec_errors  = 0;
        red_errors  = 0;
        misc_errors = 0;
        cycles      = 0;
        cycle_limit = 0;
        i_stall     = 1'b0;
        i_clear     = 1'b0;
        prev_red    = 1'b0;
        i_reset     = 1'b1;
        i_fetch     = '0;
        m_stack     = '{default: '0};
        m_ptr       = '0;
        m_ppc       = '0;
        pc_ctr      = 32'h0000_8000;

        add_instr("ldm_split", 32'hE890_002A, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("ldm_empty", 32'hE890_0000, predecode_pkg::wt, 1'b1, 32'h40);
        add_instr("stm_split", 32'hE880_000F, predecode_pkg::wnt, 1'b1, 32'h44);
        add_instr("b_al_miss", 32'hEA00_0010, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("b_al_hit", 32'hEA00_0010, predecode_pkg::snt, 1'b1, pc_ctr + 32'h48);
        add_instr("bne_not_taken", 32'h1A00_0004, predecode_pkg::wnt, 1'b0, 32'd0);
        add_instr("bne_taken", 32'h1AFF_FFF0, predecode_pkg::wt, 1'b0, 32'd0);
        add_instr("call_bx", 32'hEB00_0020, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("ret_bx_lr", 32'hE12F_FF1E, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("call_mov", 32'hEB00_0008, predecode_pkg::st, 1'b0, 32'd0);
        add_instr("ret_mov_pc_lr", 32'hE1A0_F00E, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("call_ldm", 32'hEB00_0100, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("ret_ldm_pc", 32'hE8BD_8010, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("call_ldr", 32'hEBFF_FF00, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("ret_ldr_sp", 32'hE49D_F004, predecode_pkg::snt, 1'b0, 32'd0);
        for (i = 0; i < 10; i++)
                add_instr("nest_call", 32'hEB00_0040 + i, predecode_pkg::snt, 1'b0, 32'd0);
        for (i = 0; i < 10; i++)
                add_instr("nest_ret", 32'hE12F_FF1E, predecode_pkg::snt, 1'b0, 32'd0);
        add_instr("jt_ldr", 32'hE590_F000, predecode_pkg::wt, 1'b1, 32'h1234);
        add_instr("jt_add", 32'hE08F_F000, predecode_pkg::wnt, 1'b1, 32'h5678);
        add_instr("jt_mov", 32'hE1A0_F001, predecode_pkg::st, 1'b0, 32'd0);
        add_instr("other_btb", 32'hE082_1003, predecode_pkg::st, 1'b1, 32'h9ABC);
        add_instr("outside_clear", 32'hE890_000F, predecode_pkg::snt, 1'b0, 32'd0, 1);

        ins = '{32'hEA00_0000, 32'h1A00_0000, 32'hEB00_0000, 32'hE12F_FF1E,
                32'hE590_F000, 32'hE082_1003, 32'hE890_0000, 32'hE1A0_F00E};
        for (i = 0; i < 40; i++)
        begin
                int t;
                t = $urandom % 8;
                if (t < 3)
                        ins[t][23:0] = $urandom;
                if (t == 6)
                        ins[t][15:0] = $urandom;
                add_instr("random", ins[t], predecode_pkg::taken_t'($urandom % 4),
                          $urandom % 2, ($urandom % 2) ? pc_ctr + 32'd4 : $urandom);
        end

        total = 0;
        foreach (fetch_q[j])
                total += count_uops(fetch_q[j].instr);
        cycle_limit = 4 * total + 100;

        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        foreach (fetch_q[j])
        begin
                if (clear_q[j])
                        send_with_clear(fetch_q[j], name_q[j]);
                else
                        send_instr(fetch_q[j], name_q[j]);
        end
        drain_idle(3);
        if (exp_dec_q.size() != 0)
        begin
                misc_errors++;
                $display("%0d expected outputs never appeared", exp_dec_q.size());
        end

        $display("Errors: decode %0d, redirect %0d, other %0d",
                 dec_errors, red_errors, misc_errors);
        if (dec_errors + red_errors + misc_errors == 0)
                $display("PASS: all tests");
        else
                $display("FAIL: see errors above");
        $finish;
end

endmodule

// ==== verilog/predecode_top.sv ====
/*
 * Pre-decode stage top level.
 * Skid register, block-transfer sequencer and branch pre-decoder,
 * with the stage's own redirect fed back as a clear.
 */
`timescale 1ns/1ps

module predecode_top
#(
        parameter int RAS_DEPTH = 8
)
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  predecode_pkg::fetch_t    i_fetch,
        input  logic                     i_stall,
        input  logic                     i_clear,
        output predecode_pkg::decode_t   o_decode,
        output predecode_pkg::redirect_t o_redirect,
        output logic                     o_stall_from_decode
);

predecode_pkg::fetch_t w_cur;
predecode_pkg::uop_t   w_uop;
logic                  w_seq_busy;

predecode_skid u_skid
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_clear             (i_clear),
        .i_stall             (i_stall),
        .i_self_clear        (o_redirect.clear),
        .i_fetch             (i_fetch),
        .i_seq_busy          (w_seq_busy),
        .o_cur               (w_cur),
        .o_stall_from_decode (o_stall_from_decode)
);

block_xfer_sequencer u_seq
(
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_clear      (i_clear),
        .i_stall      (i_stall),
        .i_self_clear (o_redirect.clear),
        .i_cur        (w_cur),
        .o_uop        (w_uop),
        .o_busy       (w_seq_busy)
);

branch_predecode
#(
        .RAS_DEPTH  (RAS_DEPTH)
)
u_bpd
(
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_clear    (i_clear),
        .i_stall    (i_stall),
        .i_uop      (w_uop),
        .o_decode   (o_decode),
        .o_redirect (o_redirect)
);

endmodule

// ==== verilog/branch_predecode.sv ====
/*
 * Branch pre-decoder.
 * Classifies each finished instruction as call, return, jump table or
 * other, checks the predictor's guess, keeps the return address stack
 * and registers the decode output together with any fetch redirect.
 */
`timescale 1ns/1ps

module branch_predecode
#(
        parameter int RAS_DEPTH = 8
)
(
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_clear,
        input  logic                     i_stall,
        input  predecode_pkg::uop_t      i_uop,
        output predecode_pkg::decode_t   o_decode,
        output predecode_pkg::redirect_t o_redirect
);

logic [31:0]              w_pc_plus_4;
logic [31:0]              w_branch_target;
logic [31:0]              w_ras_top;
logic [31:0]              w_target;
logic                     w_is_branch;
logic                     w_is_return;
logic                     w_is_jump_table;
logic                     w_ls_load_pc;
logic                     w_guess_taken;
logic                     w_push;
logic                     w_pop;
logic                     w_update;
predecode_pkg::taken_t    w_taken_nxt;
logic [31:0]              w_ppc_nxt;
predecode_pkg::redirect_t w_redirect_nxt;

////////////////////
// Classify.
////////////////////

always_comb
begin
        w_pc_plus_4     = i_uop.pc + 32'd4;
        w_branch_target = i_uop.pc + 32'd8 +
                          {{6{i_uop.instr[23]}}, i_uop.instr[23:0], 2'b00};

        w_ls_load_pc = ((i_uop.instr ==? predecode_pkg::ls_imm_pattern) ||
                        (i_uop.instr ==? predecode_pkg::ls_reg_pattern)) &&
                       i_uop.instr[20] && (i_uop.instr[15:12] == predecode_pkg::arch_pc);

        w_is_branch = i_uop.instr[27:25] == 3'b101;

        // BX LR, MOV PC,LR, LDM with PC, load to PC based on SP.
        w_is_return = ((i_uop.instr ==? predecode_pkg::bx_pattern) &&
                       (i_uop.instr[3:0] == predecode_pkg::arch_lr)) ||
                      (i_uop.instr[27:0] == {3'b000, predecode_pkg::op_mov, 1'b0, 4'd0,
                                             predecode_pkg::arch_pc, 8'd0,
                                             predecode_pkg::arch_lr}) ||
                      ((i_uop.instr[27:25] == 3'b100) && i_uop.instr[20] && i_uop.instr[15]) ||
                      (w_ls_load_pc && (i_uop.instr[19:16] == predecode_pkg::arch_sp));

        // Computed jumps through ADD or MOV to PC.
        w_is_jump_table = w_ls_load_pc ||
                          ((i_uop.instr[27:26] == 2'b00) &&
                           (i_uop.instr[15:12] == predecode_pkg::arch_pc) &&
                           (i_uop.instr[25] || !i_uop.instr[4] || !i_uop.instr[7]) &&
                           ((i_uop.instr[24:21] == predecode_pkg::op_add) ||
                            (i_uop.instr[24:21] == predecode_pkg::op_mov)));

        w_guess_taken = (i_uop.taken == predecode_pkg::wt) ||
                        (i_uop.taken == predecode_pkg::st) ||
                        (i_uop.instr[31:28] == predecode_pkg::cond_al);

        w_target = w_is_branch ? w_branch_target : w_ras_top;
end

////////////////////
// Check prediction.
////////////////////

always_comb
begin
        w_taken_nxt    = i_uop.taken;
        w_ppc_nxt      = o_decode.ppc;
        w_redirect_nxt = '0;
        w_push         = 1'b0;
        w_pop          = 1'b0;

        if (!i_uop.valid)
        begin
                w_taken_nxt = predecode_pkg::snt;
        end
        else if (!i_uop.last)
        begin
                // Earlier micro-ops of a block transfer pass untouched.
        end
        else if (w_is_branch || w_is_return)
        begin
                if (w_guess_taken)
                begin
                        w_ppc_nxt            = w_target;
                        w_redirect_nxt.pc    = w_target;
                        w_redirect_nxt.clear = !i_uop.pred_valid ||
                                               (i_uop.pred_addr != w_target);
                        if (i_uop.instr[31:28] == predecode_pkg::cond_al)
                                w_taken_nxt = predecode_pkg::st;
                        w_push = w_is_branch && i_uop.instr[24];
                        w_pop  = w_is_return;
                end
                else
                begin
                        w_ppc_nxt = w_pc_plus_4;
                end
        end
        else if (w_is_jump_table)
        begin
                // Trust the predictor.
        end
        else
        begin
                w_taken_nxt = predecode_pkg::snt;
                if (i_uop.pred_valid)
                begin
                        w_ppc_nxt                = w_pc_plus_4;
                        w_redirect_nxt.clear     = 1'b1;
                        w_redirect_nxt.pc        = w_pc_plus_4;
                        w_redirect_nxt.clear_btb = 1'b1;
                end
        end
end

// The stack moves only on cycles that also update the outputs.
assign w_update = !i_clear && !i_stall && !o_redirect.clear;

return_address_stack
#(
        .RAS_DEPTH   (RAS_DEPTH)
)
u_ras
(
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_push      (w_push && w_update),
        .i_pop       (w_pop && w_update),
        .i_push_addr (w_pc_plus_4),
        .o_top       (w_ras_top)
);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_decode.valid       <= 1'b0;
                o_decode.ppc         <= '0;
                o_redirect.clear     <= 1'b0;
                o_redirect.clear_btb <= 1'b0;
        end
        else if (i_clear || (!i_stall && o_redirect.clear))
        begin
                o_decode.valid       <= 1'b0;
                o_redirect.clear     <= 1'b0;
                o_redirect.clear_btb <= 1'b0;
        end
        else if (!i_stall)
        begin
                o_decode.valid <= i_uop.valid;
                o_decode.instr <= i_uop.instr;
                o_decode.pc    <= i_uop.pc;
                o_decode.taken <= w_taken_nxt;
                o_decode.ppc   <= w_ppc_nxt;
                o_redirect     <= w_redirect_nxt;
        end
end

endmodule

// ==== verilog/return_address_stack.sv ====
/*
 * Return address stack.
 * Circular array of return addresses with a wrapping pointer. Deep
 * call nesting overwrites the oldest entries.
 */
`timescale 1ns/1ps

module return_address_stack
#(
        parameter int RAS_DEPTH = 8
)
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_push,
        input  logic        i_pop,
        input  logic [31:0] i_push_addr,
        output logic [31:0] o_top
);

localparam int ptr_w = $clog2(RAS_DEPTH);

logic [RAS_DEPTH-1:0][31:0] r_stack;
logic [ptr_w-1:0]           r_ptr;
logic [ptr_w-1:0]           w_ptr_below;

// The pointer marks the next free slot; the top sits just below it.
always_comb
begin
        w_ptr_below = r_ptr - ptr_w'(1);
        o_top       = r_stack[w_ptr_below];
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                r_stack <= '0;
                r_ptr   <= '0;
        end
        else if (i_push)
        begin
                r_stack[r_ptr] <= i_push_addr;
                r_ptr          <= r_ptr + ptr_w'(1);
        end
        else if (i_pop)
        begin
                r_ptr <= w_ptr_below;
        end
end

// Call and return are never classified for the same micro-op.
a_push_pop_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_push && i_pop));

endmodule

// ==== verilog/block_xfer_sequencer.sv ====
/*
 * Block-transfer sequencer.
 * Splits a load/store-multiple into one micro-op per listed register,
 * lowest register first. Everything else passes as a single micro-op.
 */
`timescale 1ns/1ps

module block_xfer_sequencer
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  logic                  i_stall,
        input  logic                  i_self_clear,
        input  predecode_pkg::fetch_t i_cur,
        output predecode_pkg::uop_t   o_uop,
        output logic                  o_busy
);

// List bits already issued for the current instruction.
logic [15:0] r_done;

logic [15:0] w_remaining;
logic [15:0] w_lowest;
logic        w_is_block;

////////////////////
// Register list.
////////////////////

always_comb
begin
        // An empty list is treated as an ordinary instruction.
        w_is_block  = i_cur.valid && (i_cur.instr[27:25] == 3'b100) && (|i_cur.instr[15:0]);
        w_remaining = i_cur.instr[15:0] & ~r_done;

        // Isolate the lowest set bit.
        w_lowest    = w_remaining & (~w_remaining + 16'd1);

        // More micro-ops remain after this one.
        o_busy      = w_is_block && (|(w_remaining & ~w_lowest));
end

////////////////////
// Micro-op.
////////////////////

always_comb
begin
        o_uop.pred_valid = i_cur.pred_valid;
        o_uop.pred_addr  = i_cur.pred_addr;
        o_uop.taken      = i_cur.taken;
        o_uop.pc         = i_cur.pc;
        o_uop.valid      = i_cur.valid;
        o_uop.instr      = i_cur.instr;

        if (w_is_block)
                o_uop.instr[15:0] = w_lowest;

        o_uop.last = !o_busy;
end

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                r_done <= '0;
        end
        else if (!i_stall)
        begin
                // Restart on a redirect or once the last micro-op goes out.
                if (i_self_clear || !o_busy)
                        r_done <= '0;
                else
                        r_done <= r_done | w_lowest;
        end
end

// Each split micro-op carries a single register. The skid must keep
// the instruction steady for the issued bits to stay meaningful.
a_single_list_bit: assert property (@(posedge i_clk) disable iff (i_reset)
        w_is_block |-> $onehot(o_uop.instr[15:0]));

endmodule

// ==== verilog/predecode_skid.sv ====
/*
 * Fetch stall register and skid copy.
 * Raises the fetch stall while a block transfer is being split and
 * presents the held instruction to the sequencer in that time.
 */
`timescale 1ns/1ps

module predecode_skid
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  logic                  i_stall,
        input  logic                  i_self_clear,
        input  predecode_pkg::fetch_t i_fetch,
        input  logic                  i_seq_busy,
        output predecode_pkg::fetch_t o_cur,
        output logic                  o_stall_from_decode
);

predecode_pkg::fetch_t r_skid;

// Stall follows the sequencer's busy level on a normal update.
always_ff @(posedge i_clk)
begin
        if (i_reset)
                o_stall_from_decode <= 1'b0;
        else if (i_clear)
                o_stall_from_decode <= 1'b0;
        else if (i_stall)
        begin
                // Hold.
        end
        else if (i_self_clear)
                o_stall_from_decode <= 1'b0;
        else
                o_stall_from_decode <= i_seq_busy;
end

// Track the live input while not stalled, so the copy at the rising
// edge of the stall is the block transfer being split.
always_ff @(posedge i_clk)
begin
        if (!i_stall && !o_stall_from_decode)
                r_skid <= i_fetch;
end

always_comb
begin
        o_cur = o_stall_from_decode ? r_skid : i_fetch;
end

// The held copy is always a block transfer while the fetch stall is high.
a_skid_holds_block: assert property (@(posedge i_clk) disable iff (i_reset)
        o_stall_from_decode |-> o_cur.valid && (o_cur.instr[27:25] == 3'b100));

endmodule

// ==== verilog/predecode_pkg.sv ====
/*
 * Pre-decode stage shared definitions.
 * Instruction field constants, wildcard opcode patterns, branch
 * confidence states and the bundles that move between the skid
 * register, the block-transfer sequencer and the branch pre-decoder.
 */
package predecode_pkg;

        // Branch confidence as carried with each fetched instruction.
        typedef enum logic [1:0]
        {
                snt = 2'd0,
                wnt = 2'd1,
                wt  = 2'd2,
                st  = 2'd3
        } taken_t;

        // Condition code "always".
        localparam logic [3:0] cond_al = 4'b1110;

        // Architectural register numbers.
        localparam logic [3:0] arch_sp = 4'd13;
        localparam logic [3:0] arch_lr = 4'd14;
        localparam logic [3:0] arch_pc = 4'd15;

        // Data-processing opcodes.
        localparam logic [3:0] op_add = 4'b0100;
        localparam logic [3:0] op_mov = 4'b1101;

        // Wildcard patterns, compared with ==?.
        localparam logic [31:0] bx_pattern     = 32'b????_0001_0010_1111_1111_1111_0001_????;
        localparam logic [31:0] ls_imm_pattern = 32'b????_010?_????_????_????_????_????_????;
        localparam logic [31:0] ls_reg_pattern = 32'b????_011?_????_????_????_????_???0_????;

        ////////////////////
        // Bundles.
        ////////////////////

        // One fetched instruction with the predictor's guess.
        typedef struct packed
        {
                logic        pred_valid;
                logic [31:0] pred_addr;
                taken_t      taken;
                logic [31:0] pc;
                logic [31:0] instr;
                logic        valid;
        } fetch_t;

        // One micro-op. Last marks the final micro-op of an instruction.
        typedef struct packed
        {
                logic        pred_valid;
                logic [31:0] pred_addr;
                taken_t      taken;
                logic [31:0] pc;
                logic [31:0] instr;
                logic        valid;
                logic        last;
        } uop_t;

        // Registered stage output. Ppc is the predicted next PC.
        typedef struct packed
        {
                logic        valid;
                logic [31:0] instr;
                logic [31:0] pc;
                taken_t      taken;
                logic [31:0] ppc;
        } decode_t;

        // Redirect back to fetch.
        typedef struct packed
        {
                logic        clear;
                logic [31:0] pc;
                logic        clear_btb;
        } redirect_t;

endpackage
